// ==== common/ring_node_macros.svh ====
`ifndef RING_NODE_MACROS_SVH
`define RING_NODE_MACROS_SVH

// phase error and control code widths
`define RN_ERR_W        5
`define RN_CC_W         5

// error combiner
`define RN_WEIGHT_W     4
`define RN_WEIGHT_SHIFT 3   // divides the weighted sum by 8

// loop filter gains, unsigned fixed point
`define RN_KP_W         6
`define RN_KP_FRAC      5
`define RN_KI_W         8
`define RN_KI_FRAC      7

// oscillator
`define RN_BIAS         15  // centre frequency select
`define RN_ACC_W        8

// lock detection
`define RN_LOCK_TOL     1
`define RN_LOCK_COUNT   8

`endif

// ==== common/ring_node_pkg.sv ====
package ring_node_pkg;

    `include "ring_node_macros.svh"

    // signed phase error in fpga_clk_i cycles
    typedef logic signed [`RN_ERR_W-1:0] phase_err_t;

    // signed control code, subtracted from the bias in the oscillator
    typedef logic signed [`RN_CC_W-1:0] dco_code_t;

    typedef enum logic [1:0] {
        NODE_IDLE,
        NODE_ACQUIRE,
        NODE_LOCKED
    } node_state_e;

endpackage

// ==== hw/phase_detector.sv ====
`timescale 1ns/1ps

`include "ring_node_macros.svh"

module phase_detector (
    input  logic                      fpga_clk_i,
    input  logic                      rst_i,
    input  logic                      reference_i,
    input  logic                      generated_i,
    output ring_node_pkg::phase_err_t error_o
);
    import ring_node_pkg::*;

    localparam int ERR_MAX = 2**(`RN_ERR_W-1) - 1;
    localparam int CNT_MAX = 2**(`RN_ERR_W-1);    // magnitude of the most negative error

    logic                ref_q;
    logic                gen_q;
    logic                ref_rise;
    logic                gen_rise;
    logic                busy_q;      // first edge seen, waiting for the second
    logic                ref_first_q; // reference arrived first, generated is late
    logic [`RN_ERR_W-1:0] cnt_q;
    logic                second_edge;
    phase_err_t          diff;

    assign ref_rise = reference_i & ~ref_q;
    assign gen_rise = generated_i & ~gen_q;

    assign second_edge = busy_q && (ref_first_q ? gen_rise : ref_rise);

    // signed result from the elapsed count
    always_comb begin
        int mag;
        mag = int'(cnt_q);
        if (ref_first_q) begin
            diff = phase_err_t'((mag > ERR_MAX) ? ERR_MAX : mag);
        end else begin
            diff = phase_err_t'(-mag);
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            ref_q       <= 1'b0;
            gen_q       <= 1'b0;
            busy_q      <= 1'b0;
            ref_first_q <= 1'b0;
            cnt_q       <= '0;
            error_o     <= '0;
        end else begin
            ref_q <= reference_i;
            gen_q <= generated_i;
            if (!busy_q) begin
                if (ref_rise && gen_rise) begin
                    error_o <= '0; // edges coincide
                end else if (ref_rise || gen_rise) begin
                    busy_q      <= 1'b1;
                    ref_first_q <= ref_rise;
                    cnt_q       <= 1;
                end
            end else if (second_edge) begin
                error_o <= diff;
                busy_q  <= 1'b0;
            end else if (int'(cnt_q) < CNT_MAX) begin
                cnt_q <= cnt_q + 1'b1; // saturate at the error range
            end
        end
    end

endmodule

// ==== hw/error_combiner.sv ====
`timescale 1ns/1ps

`include "ring_node_macros.svh"

module error_combiner (
    input  logic                      fpga_clk_i,
    input  logic                      rst_i,
    input  logic [`RN_WEIGHT_W-1:0]   weight_0_i,
    input  logic [`RN_WEIGHT_W-1:0]   weight_1_i,
    input  logic [`RN_WEIGHT_W-1:0]   weight_2_i,
    input  logic [`RN_WEIGHT_W-1:0]   weight_3_i,
    input  ring_node_pkg::phase_err_t error_0_i,
    input  ring_node_pkg::phase_err_t error_1_i,
    input  ring_node_pkg::phase_err_t error_2_i,
    input  ring_node_pkg::phase_err_t error_3_i,
    output ring_node_pkg::phase_err_t error_comb_o
);
    import ring_node_pkg::*;

    // room for four full-scale products
    localparam int SUM_W   = `RN_ERR_W + `RN_WEIGHT_W + 3;
    localparam int ERR_MAX = 2**(`RN_ERR_W-1) - 1;
    localparam int ERR_MIN = -(2**(`RN_ERR_W-1));

    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] scaled;
    phase_err_t              comb_d;

    // signed error times unsigned weight
    function automatic logic signed [SUM_W-1:0] weigh(
        input phase_err_t            err,
        input logic [`RN_WEIGHT_W-1:0] w
    );
        logic signed [SUM_W-1:0] e_ext;
        logic signed [SUM_W-1:0] w_ext;
        e_ext = err;   // sign extended
        w_ext = w;     // zero extended
        return e_ext * w_ext;
    endfunction

    always_comb begin
        sum = weigh(error_0_i, weight_0_i) + weigh(error_1_i, weight_1_i)
            + weigh(error_2_i, weight_2_i) + weigh(error_3_i, weight_3_i);
        scaled = sum >>> `RN_WEIGHT_SHIFT;
        if (scaled > ERR_MAX) begin
            comb_d = phase_err_t'(ERR_MAX);
        end else if (scaled < ERR_MIN) begin
            comb_d = phase_err_t'(ERR_MIN);
        end else begin
            comb_d = phase_err_t'(scaled);
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            error_comb_o <= '0;
        end else begin
            error_comb_o <= comb_d;
        end
    end

endmodule

// ==== loop_filter/loop_filter.sv ====
`timescale 1ns/1ps

`include "ring_node_macros.svh"

module loop_filter (
    input  logic                      fpga_clk_i,
    input  logic                      rst_i,
    input  logic                      update_i,
    input  ring_node_pkg::phase_err_t error_i,
    input  logic [`RN_KP_W-1:0]       kp_i,
    input  logic [`RN_KI_W-1:0]       ki_i,
    output ring_node_pkg::dco_code_t  dco_cc_o
);
    import ring_node_pkg::*;

    // integrator keeps RN_KI_FRAC fraction bits below the code
    localparam int INT_W   = `RN_CC_W + `RN_KI_FRAC;
    localparam int CC_MAX  = 2**(`RN_CC_W-1) - 1;
    localparam int CC_MIN  = -(2**(`RN_CC_W-1));
    localparam int INT_MAX = ((CC_MAX + 1) * (2**`RN_KI_FRAC)) - 1;
    localparam int INT_MIN = CC_MIN * (2**`RN_KI_FRAC);

    logic signed [INT_W-1:0] integ_q;
    logic signed [INT_W-1:0] integ_d;
    dco_code_t               cc_d;

    always_comb begin
        int err_v;
        int integ_v;
        int prop_v;
        int sum_v;

        err_v   = int'(error_i);
        integ_v = int'(integ_q) + int'(ki_i) * err_v;
        if (integ_v > INT_MAX) begin
            integ_v = INT_MAX;
        end else if (integ_v < INT_MIN) begin
            integ_v = INT_MIN;
        end
        integ_d = INT_W'(integ_v);

        // arithmetic shifts floor toward minus infinity
        prop_v = (int'(kp_i) * err_v) >>> `RN_KP_FRAC;
        sum_v  = (integ_v >>> `RN_KI_FRAC) + prop_v;
        if (sum_v > CC_MAX) begin
            sum_v = CC_MAX;
        end else if (sum_v < CC_MIN) begin
            sum_v = CC_MIN;
        end
        cc_d = dco_code_t'(sum_v);
    end

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            integ_q  <= '0;
            dco_cc_o <= '0;
        end else if (update_i) begin
            integ_q  <= integ_d;
            dco_cc_o <= cc_d; // output uses the updated integrator
        end
    end

endmodule

// ==== hw/dco.sv ====
`timescale 1ns/1ps

`include "ring_node_macros.svh"

module dco (
    input  logic                     fpga_clk_i,
    input  logic                     rst_i,
    input  logic                     run_i,
    input  ring_node_pkg::dco_code_t cc_i,
    output logic                     gen_clk_o,
    output logic                     gen_div8_o
);

    localparam int ACC_W = `RN_ACC_W;
    localparam int MSB   = ACC_W - 1;

    logic [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] step;
    logic             msb_q;   // previous top bit for edge detection
    logic [2:0]       div_q;

    // frequency select, larger code means slower clock
    assign step = ACC_W'(`RN_BIAS - int'(cc_i) + 1);

    assign gen_clk_o  = acc_q[MSB];
    assign gen_div8_o = div_q[2];

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            acc_q <= '0;
            msb_q <= 1'b0;
            div_q <= '0;
        end else if (!run_i) begin
            acc_q <= '0; // stopped oscillator restarts from phase zero
            msb_q <= 1'b0;
            div_q <= '0;
        end else begin
            acc_q <= acc_q + step;
            msb_q <= acc_q[MSB];
            if (acc_q[MSB] && !msb_q) begin
                div_q <= div_q + 1'b1;
            end
        end
    end

endmodule

// ==== hw/node_ctrl.sv ====
`timescale 1ns/1ps

`include "ring_node_macros.svh"

module node_ctrl (
    input  logic                      fpga_clk_i,
    input  logic                      rst_i,
    input  logic                      enable_i,
    input  logic                      gen_div8_i,
    input  ring_node_pkg::phase_err_t error_i,
    output logic                      run_o,
    output logic                      update_o,
    output logic                      lock_o
);
    import ring_node_pkg::*;

    localparam int CNT_W = $clog2(`RN_LOCK_COUNT + 1);

    node_state_e      state_q;
    node_state_e      state_d;
    logic [CNT_W-1:0] close_cnt_q;
    logic [CNT_W-1:0] close_cnt_d;
    logic             div_q;
    logic             div_rise;
    logic             close;

    assign div_rise = gen_div8_i & ~div_q;

    always_comb begin
        int err_v;
        err_v = int'(error_i);
        close = (err_v <= `RN_LOCK_TOL) && (err_v >= -`RN_LOCK_TOL);
    end

    always_comb begin
        state_d     = state_q;
        close_cnt_d = close_cnt_q;
        case (state_q)
            NODE_IDLE: begin
                close_cnt_d = '0;
                if (enable_i) begin
                    state_d = NODE_ACQUIRE;
                end
            end
            NODE_ACQUIRE: begin
                if (update_o) begin
                    if (close) begin
                        close_cnt_d = close_cnt_q + 1'b1;
                        if (int'(close_cnt_d) >= `RN_LOCK_COUNT) begin
                            state_d = NODE_LOCKED;
                        end
                    end else begin
                        close_cnt_d = '0;
                    end
                end
            end
            NODE_LOCKED: begin
                if (update_o && !close) begin // a single large error drops lock
                    state_d     = NODE_ACQUIRE;
                    close_cnt_d = '0;
                end
            end
            default: state_d = NODE_IDLE;
        endcase
        if (!enable_i) begin
            state_d     = NODE_IDLE;
            close_cnt_d = '0;
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            state_q     <= NODE_IDLE;
            close_cnt_q <= '0;
            div_q       <= 1'b0;
            update_o    <= 1'b0;
        end else begin
            state_q     <= state_d;
            close_cnt_q <= close_cnt_d;
            div_q       <= gen_div8_i;
            update_o    <= div_rise && enable_i && (state_q != NODE_IDLE);
        end
    end

    assign run_o  = (state_q != NODE_IDLE);
    assign lock_o = (state_q == NODE_LOCKED); // moves with the filter output

endmodule

// ==== hw/ring_node.sv ====
`timescale 1ns/1ps

`include "ring_node_macros.svh"

module ring_node (
    input  logic                      fpga_clk_i,
    input  logic                      rst_i,
    input  logic                      enable_i,
    input  logic                      ref_left_i,
    input  logic                      ref_above_i,
    input  ring_node_pkg::phase_err_t error_right_i,
    input  ring_node_pkg::phase_err_t error_bottom_i,
    input  logic [`RN_KP_W-1:0]       kp_i,
    input  logic [`RN_KI_W-1:0]       ki_i,
    input  logic [`RN_WEIGHT_W-1:0]   weight_left_i,
    input  logic [`RN_WEIGHT_W-1:0]   weight_above_i,
    input  logic [`RN_WEIGHT_W-1:0]   weight_right_i,
    input  logic [`RN_WEIGHT_W-1:0]   weight_below_i,
    output logic                      gen_clk_o,
    output logic                      gen_div8_o,
    output ring_node_pkg::phase_err_t error_left_o,
    output ring_node_pkg::phase_err_t error_above_o,
    output ring_node_pkg::dco_code_t  dco_cc_o,
    output logic                      lock_o
);
    import ring_node_pkg::*;

    phase_err_t error_comb;
    logic       run;
    logic       update;

    // divided clock is the reference seen by the neighbours
    phase_detector pdet_left (
        .fpga_clk_i  (fpga_clk_i),
        .rst_i       (rst_i),
        .reference_i (ref_left_i),
        .generated_i (gen_div8_o),
        .error_o     (error_left_o)
    );

    phase_detector pdet_above (
        .fpga_clk_i  (fpga_clk_i),
        .rst_i       (rst_i),
        .reference_i (ref_above_i),
        .generated_i (gen_div8_o),
        .error_o     (error_above_o)
    );

    // zero weight removes a missing neighbour
    error_combiner combiner (
        .fpga_clk_i   (fpga_clk_i),
        .rst_i        (rst_i),
        .weight_0_i   (weight_above_i),
        .weight_1_i   (weight_left_i),
        .weight_2_i   (weight_right_i),
        .weight_3_i   (weight_below_i),
        .error_0_i    (error_above_o),
        .error_1_i    (error_left_o),
        .error_2_i    (error_right_i),
        .error_3_i    (error_bottom_i),
        .error_comb_o (error_comb)
    );

    node_ctrl ctrl (
        .fpga_clk_i (fpga_clk_i),
        .rst_i      (rst_i),
        .enable_i   (enable_i),
        .gen_div8_i (gen_div8_o),
        .error_i    (error_comb),
        .run_o      (run),
        .update_o   (update),
        .lock_o     (lock_o)
    );

    loop_filter filter (
        .fpga_clk_i (fpga_clk_i),
        .rst_i      (rst_i),
        .update_i   (update),
        .error_i    (error_comb),
        .kp_i       (kp_i),
        .ki_i       (ki_i),
        .dco_cc_o   (dco_cc_o)
    );

    dco osc (
        .fpga_clk_i (fpga_clk_i),
        .rst_i      (rst_i),
        .run_i      (run),
        .cc_i       (dco_cc_o),
        .gen_clk_o  (gen_clk_o),
        .gen_div8_o (gen_div8_o)
    );

endmodule

// ==== testbench/tb_ring_node_model.svh ====
`ifndef TB_RING_NODE_MODEL_SVH
`define TB_RING_NODE_MODEL_SVH

// saturate to a signed word of the given width
function automatic int clamp_signed(input int value, input int width);
    int hi;
    int lo;
    hi = (1 << (width - 1)) - 1;
    lo = -(1 << (width - 1));
    if (value > hi) begin
        return hi;
    end
    if (value < lo) begin
        return lo;
    end
    return value;
endfunction

// value divided by 2**shift, rounded toward minus infinity
function automatic int floor_shift(input int value, input int shift);
    int div;
    div = 1 << shift;
    if (value >= 0) begin
        return value / div;
    end
    return -((-value + div - 1) / div);
endfunction

// weighted sum of the four neighbour errors
function automatic int combine(
    input int w_a,
    input int e_a,
    input int w_b,
    input int e_b,
    input int w_c,
    input int e_c,
    input int w_d,
    input int e_d
);
    int sum;
    sum = w_a * e_a + w_b * e_b + w_c * e_c + w_d * e_d;
    return clamp_signed(floor_shift(sum, `RN_WEIGHT_SHIFT), `RN_ERR_W);
endfunction

// integrator after one update, RN_KI_FRAC fraction bits
function automatic int integ_step(input int integ, input int err, input int ki);
    return clamp_signed(integ + ki * err, `RN_CC_W + `RN_KI_FRAC);
endfunction

// control code after one update from the old integrator
function automatic int filter_step(input int integ, input int err, input int kp, input int ki);
    int integ_new;
    int code;
    integ_new = integ_step(integ, err, ki);
    code = floor_shift(integ_new, `RN_KI_FRAC) + floor_shift(kp * err, `RN_KP_FRAC);
    return clamp_signed(code, `RN_CC_W);
endfunction

// close-update counter, locked once it reaches RN_LOCK_COUNT
function automatic int lock_next(input int cnt, input int err);
    if (err > `RN_LOCK_TOL || err < -`RN_LOCK_TOL) begin
        return 0;
    end
    if (cnt < `RN_LOCK_COUNT) begin
        return cnt + 1;
    end
    return cnt;
endfunction

`endif

// ==== testbench/tb_ring_node.sv ====
`timescale 1ns/1ps

`include "ring_node_macros.svh"

module tb_ring_node;
    import ring_node_pkg::*;

    `include "tb_ring_node_model.svh"

    typedef logic [`RN_WEIGHT_W-1:0] weight_t;
    typedef logic [`RN_KP_W-1:0]     kp_t;
    typedef logic [`RN_KI_W-1:0]     ki_t;

    localparam int NUM_TESTS      = 6;
    localparam int MAX_DIV_PERIOD = 8 * (1 << `RN_ACC_W); // oscillator step of one
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 * MAX_DIV_PERIOD + 2000;
    localparam int CC_MAX         = (1 << (`RN_CC_W - 1)) - 1;
    localparam int CC_MIN         = -(1 << (`RN_CC_W - 1));

    logic       clk;
    logic       rst;
    logic       enable;
    logic       ref_left;
    logic       ref_above;
    phase_err_t error_right;
    phase_err_t error_bottom;
    kp_t        kp;
    ki_t        ki;
    weight_t    weight_left;
    weight_t    weight_above;
    weight_t    weight_right;
    weight_t    weight_below;
    logic       gen_clk;
    logic       gen_div8;
    phase_err_t error_left;
    phase_err_t error_above;
    dco_code_t  dco_cc;
    logic       lock;

    integer seed = 91706;
    string  test_name;
    int     err_cnt;
    int     check_cnt;
    int     update_cnt;
    int     cycle_cnt;
    int     period;

    // model state tracked update by update
    int integ_m;
    int lock_cnt_m;
    int left_model;
    int above_model;
    int comb_m;
    int kp_m;
    int ki_m;
    int exp_cc;

    ring_node ring_node_inst (
        .fpga_clk_i     (clk),
        .rst_i          (rst),
        .enable_i       (enable),
        .ref_left_i     (ref_left),
        .ref_above_i    (ref_above),
        .error_right_i  (error_right),
        .error_bottom_i (error_bottom),
        .kp_i           (kp),
        .ki_i           (ki),
        .weight_left_i  (weight_left),
        .weight_above_i (weight_above),
        .weight_right_i (weight_right),
        .weight_below_i (weight_below),
        .gen_clk_o      (gen_clk),
        .gen_div8_o     (gen_div8),
        .error_left_o   (error_left),
        .error_above_o  (error_above),
        .dco_cc_o       (dco_cc),
        .lock_o         (lock)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycle_cnt, test_name);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input int expected, input int actual);
        check_cnt++;
        assert (expected == actual) else begin
            err_cnt++;
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // combiner registers the mid-cycle inputs and the filter updates two edges later
    always begin
        @(posedge gen_div8);
        #50;
        if (enable && !rst) begin
            comb_m = combine(weight_above, above_model, weight_left, left_model,
                             weight_right, error_right, weight_below, error_bottom);
            kp_m = kp;
            ki_m = ki;
            @(posedge clk);
            @(posedge clk);
            #1;
            exp_cc     = filter_step(integ_m, comb_m, kp_m, ki_m);
            integ_m    = integ_step(integ_m, comb_m, ki_m);
            lock_cnt_m = lock_next(lock_cnt_m, comb_m);
            check_value("dco_cc_o", exp_cc, dco_cc);
            check_value("lock_o", (lock_cnt_m >= `RN_LOCK_COUNT) ? 1 : 0, lock);
            update_cnt++;
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        rst         = 1'b0;
        integ_m     = 0;
        lock_cnt_m  = 0;
        left_model  = 0;
        above_model = 0;
    endtask

    // returns 2 ns after the edge on which dco_cc_o changed
    task automatic wait_updates(input int n);
        repeat (n) begin
            @(posedge gen_div8);
            repeat (2) @(posedge clk);
            #2;
        end
    endtask

    task automatic apply_proportional(input int gain, input int err);
        kp          = kp_t'(gain);
        error_right = phase_err_t'(err);
        wait_updates(2);
    endtask

    task automatic pulse_ref_left();
        ref_left = 1'b1;
        @(posedge clk);
        #2;
        ref_left = 1'b0;
    endtask

    // offset is generated edge minus reference edge in cycles
    task automatic expect_left(input int offset);
        int expected;
        expected = clamp_signed(offset, `RN_ERR_W);
        check_value("error_left_o", expected, error_left);
        left_model = expected;
    endtask

    task automatic measure_after(input int k);
        @(posedge gen_div8);
        repeat (k) @(posedge clk);
        #2;
        pulse_ref_left();
        expect_left(-k);
    endtask

    task automatic measure_before(input int k);
        @(posedge gen_div8);
        #2;
        pulse_ref_left(); // coincident edges leave the detector idle
        expect_left(0);
        repeat (period - k - 1) @(posedge clk);
        #2;
        pulse_ref_left();
        repeat (k) @(posedge clk); // generated edge lands k cycles later
        #2;
        expect_left(k);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        enable       = 1'b0;
        ref_left     = 1'b0;
        ref_above    = 1'b0;
        error_right  = '0;
        error_bottom = '0;
        kp           = '0;
        ki           = '0;
        weight_left  = '0;
        weight_above = '0;
        weight_right = '0;
        weight_below = '0;
        err_cnt      = 0;
        check_cnt    = 0;
        update_cnt   = 0;
        period       = 0;

        test_name = "reset_idle";
        apply_reset();
        repeat (50) begin
            @(posedge clk);
            #2;
            check_value("gen_clk_o", 0, gen_clk);
            check_value("gen_div8_o", 0, gen_div8);
            check_value("lock_o", 0, lock);
            check_value("dco_cc_o", 0, dco_cc);
        end

        test_name    = "proportional";
        weight_right = weight_t'(8); // combined error equals error_right
        enable       = 1'b1;
        apply_reset();
        apply_proportional(16, 5);
        apply_proportional(40, -7);
        apply_proportional(63, 15);
        apply_proportional(63, -16);

        test_name = "integral_combine";
        repeat (30) begin
            weight_right = weight_t'(rand_range(0, 15));
            weight_below = weight_t'(rand_range(0, 15));
            error_right  = phase_err_t'(rand_range(-16, 15));
            error_bottom = phase_err_t'(rand_range(-16, 15));
            kp           = kp_t'(rand_range(0, 63));
            ki           = ki_t'(rand_range(0, 31));
            wait_updates(1);
        end

        test_name    = "saturation";
        weight_right = weight_t'(15);
        weight_below = weight_t'(15);
        kp           = kp_t'(63);
        ki           = ki_t'(255);
        error_right  = phase_err_t'(15);
        error_bottom = phase_err_t'(15);
        repeat (5) begin
            wait_updates(1);
            check_value("code_high", CC_MAX, dco_cc);
        end
        error_right  = phase_err_t'(-16);
        error_bottom = phase_err_t'(-16);
        repeat (5) begin
            wait_updates(1);
            check_value("code_low", CC_MIN, dco_cc);
        end

        test_name    = "lock";
        weight_right = weight_t'(8);
        weight_below = '0;
        error_bottom = '0;
        kp           = kp_t'(8);
        ki           = ki_t'(4);
        for (int i = 0; i < `RN_LOCK_COUNT; i++) begin
            error_right = phase_err_t'((i % 3) - 1); // stays within the tolerance
            wait_updates(1);
            check_value("lock_rise", (i == `RN_LOCK_COUNT - 1) ? 1 : 0, lock);
        end
        error_right = phase_err_t'(`RN_LOCK_TOL + 1);
        wait_updates(1);
        check_value("lock_drop", 0, lock);
        error_right = '0;
        wait_updates(1);
        check_value("lock_restart", 0, lock);

        test_name    = "phase_detector";
        kp           = '0;
        ki           = '0;
        error_right  = '0;
        weight_right = '0;
        weight_left  = weight_t'(8);
        apply_reset();
        @(posedge gen_clk);
        period = cycle_cnt;
        @(posedge gen_clk);
        check_value("gen_clk_period", (1 << `RN_ACC_W) / (`RN_BIAS + 1), cycle_cnt - period);
        @(posedge gen_div8);
        period = cycle_cnt;
        @(posedge gen_div8);
        period = cycle_cnt - period;
        check_value("div8_period", MAX_DIV_PERIOD / (`RN_BIAS + 1), period);
        // first generated edge still waits for its reference
        repeat (20) @(posedge clk);
        #2;
        pulse_ref_left();
        expect_left(-(period + 20));
        measure_after(0);
        measure_after(1);
        measure_after(4);
        measure_after(20);
        measure_before(1);
        measure_before(6);
        measure_before(30);

        // above detector has waited many periods for its reference
        ref_above = 1'b1;
        @(posedge clk);
        #2;
        ref_above    = 1'b0;
        weight_above = weight_t'(4);
        kp           = kp_t'(32); // code follows the combined error
        above_model  = clamp_signed(-period, `RN_ERR_W);
        check_value("error_above_o", above_model, error_above);
        check_value("error_left_held", left_model, error_left);
        wait_updates(1);

        assert (update_cnt > 0) else begin
            err_cnt++;
            $display("no filter update was observed during the run");
        end
        $display("checks %0d, filter updates %0d, errors %0d", check_cnt, update_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
+incdir+testbench
common/ring_node_pkg.sv
hw/phase_detector.sv
hw/error_combiner.sv
loop_filter/loop_filter.sv
hw/dco.sv
hw/node_ctrl.sv
hw/ring_node.sv
testbench/tb_ring_node.sv

// ==== Bender.yml ====
package:
  name: ring_node

sources:
  - include_dirs:
      - common
    files:
      - common/ring_node_pkg.sv
      - hw/phase_detector.sv
      - hw/error_combiner.sv
      - loop_filter/loop_filter.sv
      - hw/dco.sv
      - hw/node_ctrl.sv
      - hw/ring_node.sv

  - target: test
    include_dirs:
      - common
      - testbench
    files:
      - testbench/tb_ring_node.sv
